// File: Makefile
VERILATOR ?= verilator
TOP       ?= shared_bus_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
+incdir+src
src/bus_pkg.sv
src/mem_pkg.sv
src/bus_arbiter.sv
src/bus_interconnect.sv
src/mem_slave.sv
src/shared_bus.sv
test/shared_bus_tb.sv

// File: src/bus_arbiter.sv
`include "bus_params.svh"

module bus_arbiter (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req0,
  input  logic                 req1,
  output logic                 grant0,
  output logic                 grant1,
  output bus_pkg::master_sel_t master_sel
);

  localparam int TIMER_WIDTH = $clog2(`ARB_HOLD_LIMIT + 1);
  localparam logic [TIMER_WIDTH-1:0] HOLD_LIMIT = TIMER_WIDTH'(`ARB_HOLD_LIMIT);

  typedef enum logic [1:0] {
    arb_idle,
    arb_grant0,
    arb_grant1
  } arb_state_t;

  arb_state_t state;
  logic [TIMER_WIDTH-1:0] timer;  // Granted cycles of the current owner
  logic own_req;
  logic other_req;
  logic hold_expired;

  // Requests as seen from the current owner
  assign own_req   = (state == arb_grant1) ? req1 : req0;
  assign other_req = (state == arb_grant1) ? req0 : req1;

  // Owner has used up its turn and someone is waiting
  assign hold_expired = (timer == HOLD_LIMIT) && other_req;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= arb_idle;
      timer      <= '0;
      master_sel <= 1'b0;
    end else begin
      case (state)
        arb_idle: begin
          if (req0) begin  // Master 0 first from idle
            state      <= arb_grant0;
            master_sel <= 1'b0;
            timer      <= TIMER_WIDTH'(1);
          end else if (req1) begin
            state      <= arb_grant1;
            master_sel <= 1'b1;
            timer      <= TIMER_WIDTH'(1);
          end
        end
        arb_grant0, arb_grant1: begin
          if (own_req && !hold_expired) begin
            if (timer != HOLD_LIMIT) begin
              timer <= timer + 1'b1;  // Saturates while nobody waits
            end
          end else if (other_req) begin
            // Hand over to the waiting master
            state      <= (state == arb_grant0) ? arb_grant1 : arb_grant0;
            master_sel <= (state == arb_grant0);
            timer      <= TIMER_WIDTH'(1);
          end else begin
            state <= arb_idle;  // master_sel holds its value
            timer <= '0;
          end
        end
        default: begin
          state <= arb_idle;
        end
      endcase
    end
  end

  assign grant0 = (state == arb_grant0);
  assign grant1 = (state == arb_grant1);

endmodule

// File: src/bus_interconnect.sv
`include "bus_params.svh"

module bus_interconnect (
  input  bus_pkg::master_sel_t master_sel,
  input  logic                 m0_write,
  input  bus_pkg::addr_t       m0_address,
  input  logic                 m0_valid,
  input  bus_pkg::data_t       m0_wdata,
  input  logic                 m1_write,
  input  bus_pkg::addr_t       m1_address,
  input  logic                 m1_valid,
  input  bus_pkg::data_t       m1_wdata,
  input  bus_pkg::data_t       s0_rdata,
  input  logic                 s0_done,
  input  bus_pkg::data_t       s1_rdata,
  input  logic                 s1_done,
  input  bus_pkg::data_t       s2_rdata,
  input  logic                 s2_done,
  output logic                 bus_write,
  output mem_pkg::mem_offset_t bus_offset,
  output bus_pkg::data_t       bus_wdata,
  output logic                 s0_valid,
  output logic                 s1_valid,
  output logic                 s2_valid,
  output bus_pkg::data_t       rdata,
  output logic                 done
);
  import bus_pkg::*;

  addr_t      address;
  logic       valid;
  slave_sel_t sel;

  // Owner's request onto the shared path
  assign address   = master_sel ? m1_address : m0_address;
  assign valid     = master_sel ? m1_valid : m0_valid;
  assign bus_write = master_sel ? m1_write : m0_write;
  assign bus_wdata = master_sel ? m1_wdata : m0_wdata;

  // Split address into select and offset
  assign sel        = address[`BUS_ADDR_WIDTH-1 -: `SLAVE_SEL_WIDTH];
  assign bus_offset = address[`BUS_ADDR_WIDTH-`SLAVE_SEL_WIDTH-1:0];

  assign s0_valid = valid && (sel == slave_sel_t'(0));
  assign s1_valid = valid && (sel == slave_sel_t'(1));
  assign s2_valid = valid && (sel == slave_sel_t'(2));

  // Response from the addressed slave
  always_comb begin
    case (sel)
      slave_sel_t'(0): begin
        rdata = s0_rdata;
        done  = s0_done;
      end
      slave_sel_t'(1): begin
        rdata = s1_rdata;
        done  = s1_done;
      end
      slave_sel_t'(2): begin
        rdata = s2_rdata;
        done  = s2_done;
      end
      default: begin  // Unmapped, nobody answers
        rdata = '0;
        done  = 1'b0;
      end
    endcase
  end

endmodule

// File: src/bus_params.svh
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// Bus widths
`define BUS_ADDR_WIDTH 14
`define BUS_DATA_WIDTH 8

// Top address bits that pick a slave
`define SLAVE_SEL_WIDTH 2

// Slave sizes in bytes
`define SLAVE0_DEPTH 2048
`define SLAVE12_DEPTH 4096

`define MEM_LATENCY 3       // Cycles from capture edge to done

// Longest run of granted cycles while the other master waits
`define ARB_HOLD_LIMIT 15

`endif

// File: src/bus_pkg.sv
`include "bus_params.svh"

// Types seen on the master side of the bus
package bus_pkg;

  // Select field in the top bits, slave offset below it
  typedef logic [`BUS_ADDR_WIDTH-1:0] addr_t;

  typedef logic [`BUS_DATA_WIDTH-1:0] data_t;  // One byte per transfer

  typedef logic [`SLAVE_SEL_WIDTH-1:0] slave_sel_t;

  // Current bus owner
  typedef logic master_sel_t;  // 0 is master 0, 1 is master 1

endpackage

// File: src/mem_pkg.sv
`include "bus_params.svh"

// Types on the memory side of the interconnect
package mem_pkg;

  // Address bits below the select field
  typedef logic [`BUS_ADDR_WIDTH-`SLAVE_SEL_WIDTH-1:0] mem_offset_t;

  typedef enum logic [1:0] {
    mem_idle,       // Waiting for valid
    mem_servicing,  // Latency count running
    mem_response    // Done high for one cycle
  } mem_state_t;

endpackage

// File: src/mem_slave.sv
`include "bus_params.svh"

module mem_slave #(
  parameter int DEPTH = 4096
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       valid,
  input  logic                       write,
  input  mem_pkg::mem_offset_t       offset,
  input  logic [`BUS_DATA_WIDTH-1:0] wdata,
  output logic [`BUS_DATA_WIDTH-1:0] rdata,
  output logic                       done
);
  import mem_pkg::*;

  localparam int INDEX_WIDTH = $clog2(DEPTH);
  localparam int COUNT_WIDTH = $clog2(`MEM_LATENCY + 1);

  mem_state_t state;
  logic [COUNT_WIDTH-1:0] count;  // Service cycles so far

  // Captured request
  logic [INDEX_WIDTH-1:0]     index_q;
  logic                       write_q;
  logic [`BUS_DATA_WIDTH-1:0] wdata_q;

  logic [`BUS_DATA_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= mem_idle;
      count <= '0;
      done  <= 1'b0;
    end else begin
      case (state)
        mem_idle: begin
          if (valid) begin
            state <= mem_servicing;
            count <= COUNT_WIDTH'(1);  // Capture edge counts as the first
          end
        end
        mem_servicing: begin
          if (count == COUNT_WIDTH'(`MEM_LATENCY)) begin
            state <= mem_response;
            done  <= 1'b1;
          end else begin
            count <= count + 1'b1;
          end
        end
        mem_response: begin
          state <= mem_idle;
          done  <= 1'b0;
        end
        default: begin
          state <= mem_idle;
        end
      endcase
    end
  end

  // Low offset bits only, upper ones alias in smaller slaves
  always_ff @(posedge clock) begin
    if (state == mem_idle && valid) begin
      index_q <= offset[INDEX_WIDTH-1:0];
      write_q <= write;
      wdata_q <= wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (state == mem_servicing) begin
      if (write_q) begin
        mem[index_q] <= wdata_q;
      end else begin
        rdata <= mem[index_q];  // Stable through the response cycle
      end
    end
  end

endmodule

// File: src/shared_bus.sv
`include "bus_params.svh"

module shared_bus (
  input  logic           clock,
  input  logic           reset,
  input  logic           m0_request,
  input  logic           m0_write,
  input  bus_pkg::addr_t m0_address,
  input  logic           m0_valid,
  input  bus_pkg::data_t m0_wdata,
  input  logic           m1_request,
  input  logic           m1_write,
  input  bus_pkg::addr_t m1_address,
  input  logic           m1_valid,
  input  bus_pkg::data_t m1_wdata,
  output logic           m0_grant,
  output bus_pkg::data_t m0_rdata,
  output logic           m0_done,
  output logic           m1_grant,
  output bus_pkg::data_t m1_rdata,
  output logic           m1_done
);
  import bus_pkg::*;
  import mem_pkg::*;

  master_sel_t master_sel;

  // Shared request path
  logic        bus_write;
  mem_offset_t bus_offset;
  data_t       bus_wdata;

  // Per slave handshake
  logic  s0_valid, s1_valid, s2_valid;
  data_t s0_rdata, s1_rdata, s2_rdata;
  logic  s0_done, s1_done, s2_done;

  data_t bus_rdata;
  logic  bus_done;

  bus_arbiter i_arbiter (
    .clock      (clock),
    .reset      (reset),
    .req0       (m0_request),
    .req1       (m1_request),
    .grant0     (m0_grant),
    .grant1     (m1_grant),
    .master_sel (master_sel)
  );

  bus_interconnect i_interconnect (
    .master_sel (master_sel),
    .m0_write   (m0_write),
    .m0_address (m0_address),
    .m0_valid   (m0_valid),
    .m0_wdata   (m0_wdata),
    .m1_write   (m1_write),
    .m1_address (m1_address),
    .m1_valid   (m1_valid),
    .m1_wdata   (m1_wdata),
    .s0_rdata   (s0_rdata),
    .s0_done    (s0_done),
    .s1_rdata   (s1_rdata),
    .s1_done    (s1_done),
    .s2_rdata   (s2_rdata),
    .s2_done    (s2_done),
    .bus_write  (bus_write),
    .bus_offset (bus_offset),
    .bus_wdata  (bus_wdata),
    .s0_valid   (s0_valid),
    .s1_valid   (s1_valid),
    .s2_valid   (s2_valid),
    .rdata      (bus_rdata),
    .done       (bus_done)
  );

  // Slave 0 is half size
  mem_slave #(.DEPTH(`SLAVE0_DEPTH)) i_slave0 (
    .clock (clock), .reset (reset),
    .valid (s0_valid), .write (bus_write), .offset (bus_offset), .wdata (bus_wdata),
    .rdata (s0_rdata), .done (s0_done)
  );

  mem_slave #(.DEPTH(`SLAVE12_DEPTH)) i_slave1 (
    .clock (clock), .reset (reset),
    .valid (s1_valid), .write (bus_write), .offset (bus_offset), .wdata (bus_wdata),
    .rdata (s1_rdata), .done (s1_done)
  );

  mem_slave #(.DEPTH(`SLAVE12_DEPTH)) i_slave2 (
    .clock (clock), .reset (reset),
    .valid (s2_valid), .write (bus_write), .offset (bus_offset), .wdata (bus_wdata),
    .rdata (s2_rdata), .done (s2_done)
  );

  // Response goes to both masters, the owner acts on it
  assign m0_rdata = bus_rdata;
  assign m1_rdata = bus_rdata;
  assign m0_done  = bus_done;
  assign m1_done  = bus_done;

endmodule

// File: test/shared_bus_tb.sv
`include "bus_params.svh"

module shared_bus_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import bus_pkg::*;
  import mem_pkg::*;

  // Whole run is roughly 250 cycles
  localparam int MAX_CYCLES = 3000;
  localparam int GRANT_WAIT = 40;
  localparam int DONE_WAIT  = 20;

  logic  clock = 1'b0;
  logic  reset;
  logic  m0_request, m0_write, m0_valid;
  addr_t m0_address;
  data_t m0_wdata;
  logic  m1_request, m1_write, m1_valid;
  addr_t m1_address;
  data_t m1_wdata;
  logic  m0_grant, m0_done, m1_grant, m1_done;
  data_t m0_rdata, m1_rdata;

  integer seed = 32'h2f20_8863;
  int     cycle_count = 0;

  shared_bus i_shared_bus (.*);

  always #5 clock = ~clock;  // 10 ns period

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $fatal(1, "watchdog expired");
    end
  end

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic grant_of(input int m);
    return (m == 0) ? m0_grant : m1_grant;
  endfunction

  function automatic logic done_of(input int m);
    return (m == 0) ? m0_done : m1_done;
  endfunction

  function automatic data_t rdata_of(input int m);
    return (m == 0) ? m0_rdata : m1_rdata;
  endfunction

  function automatic data_t random_byte();
    return data_t'($random(seed));
  endfunction

  // Select field on top, slave offset below
  function automatic addr_t make_address(input int slave, input mem_offset_t offset);
    return {slave_sel_t'(slave), offset};
  endfunction

  task automatic set_request(input int m, input logic value);
    if (m == 0) begin
      m0_request = value;
    end else begin
      m1_request = value;
    end
  endtask

  task automatic drive_master(input int m, input logic valid, input logic write,
                              input addr_t address, input data_t wdata);
    if (m == 0) begin
      m0_valid   = valid;
      m0_write   = write;
      m0_address = address;
      m0_wdata   = wdata;
    end else begin
      m1_valid   = valid;
      m1_write   = write;
      m1_address = address;
      m1_wdata   = wdata;
    end
  endtask

  // Called on a falling edge with the request already up
  task automatic wait_for_grant(input int m);
    int waited = 0;
    while (!grant_of(m)) begin
      if (waited == GRANT_WAIT) begin
        stop_run($sformatf("master %0d was not granted within %0d cycles", m, GRANT_WAIT));
      end else begin
        @(negedge clock);
        waited++;
      end
    end
  endtask

  task automatic bus_transfer(input int m, input logic write, input addr_t address,
                              input data_t wdata, output data_t rdata);
    int   cycles = 0;
    logic seen = 1'b0;
    check_value($sformatf("grant of master %0d at transfer start", m),
                32'(grant_of(m)), 32'd1);
    drive_master(m, 1'b1, write, address, wdata);
    @(posedge clock);  // Capture edge
    @(negedge clock);
    seen = done_of(m);
    while (!seen && cycles < DONE_WAIT) begin
      @(negedge clock);  // One more rising edge past capture
      cycles++;
      seen = done_of(m);
    end
    if (!seen) begin
      stop_run($sformatf("no done for address 0x%0h from master %0d", address, m));
    end else begin
      check_value("cycles from capture edge to done", 32'(cycles), 32'(`MEM_LATENCY));
      rdata = rdata_of(m);
      drive_master(m, 1'b0, 1'b0, address, '0);  // Valid off before the next edge
      @(negedge clock);  // Slave back in idle after this
      check_value("done one cycle after response", 32'(done_of(m)), 32'd0);
    end
  endtask

  task automatic write_byte(input int m, input addr_t address, input data_t value);
    data_t ignored;
    bus_transfer(m, 1'b1, address, value, ignored);
  endtask

  task automatic read_check(input int m, input addr_t address, input data_t expected);
    data_t got;
    bus_transfer(m, 1'b0, address, '0, got);
    check_value($sformatf("read of 0x%0h by master %0d", address, m),
                32'(got), 32'(expected));
  endtask

  task automatic release_bus(input int m);
    set_request(m, 1'b0);
    @(negedge clock);
    check_value($sformatf("grant of master %0d after release", m),
                32'(grant_of(m)), 32'd0);
  endtask

  task automatic test_reset_state();
    repeat (8) begin
      check_value("m0_grant with no request", 32'(m0_grant), 32'd0);
      check_value("m1_grant with no request", 32'(m1_grant), 32'd0);
      check_value("m0_done with no request", 32'(m0_done), 32'd0);
      check_value("m1_done with no request", 32'(m1_done), 32'd0);
      @(negedge clock);
    end
  endtask

  task automatic test_write_read_slaves();
    mem_offset_t offsets [4] = '{12'h000, 12'h155, 12'h2aa, 12'h7ff};
    addr_t addresses [$];
    data_t values [$];
    data_t value;
    set_request(0, 1'b1);
    wait_for_grant(0);
    for (int s = 0; s < 3; s++) begin
      foreach (offsets[i]) begin
        value = random_byte();
        addresses.push_back(make_address(s, offsets[i]));
        values.push_back(value);
        write_byte(0, make_address(s, offsets[i]), value);
      end
    end
    foreach (addresses[i]) begin
      read_check(0, addresses[i], values[i]);
    end
    release_bus(0);
  endtask

  task automatic test_independence_alias();
    data_t base;
    data_t late;
    base = random_byte();
    late = random_byte();
    set_request(0, 1'b1);
    wait_for_grant(0);
    // Same offset, three different bytes
    write_byte(0, make_address(0, 12'h001), base);
    write_byte(0, make_address(1, 12'h001), base ^ 8'h5a);
    write_byte(0, make_address(2, 12'h001), base ^ 8'ha5);
    read_check(0, make_address(0, 12'h001), base);
    read_check(0, make_address(1, 12'h001), base ^ 8'h5a);
    read_check(0, make_address(2, 12'h001), base ^ 8'ha5);
    // Slave 0 decodes 11 offset bits
    read_check(0, make_address(0, 12'h801), base);
    write_byte(0, make_address(0, 12'h802), late);
    read_check(0, make_address(0, 12'h002), late);
    write_byte(0, make_address(1, 12'h801), ~(base ^ 8'h5a));  // Full size, no alias
    read_check(0, make_address(1, 12'h001), base ^ 8'h5a);
    release_bus(0);
  endtask

  task automatic test_priority_from_idle();
    data_t value;
    value = random_byte();
    check_value("m0_grant before both request", 32'(m0_grant), 32'd0);
    check_value("m1_grant before both request", 32'(m1_grant), 32'd0);
    set_request(0, 1'b1);
    set_request(1, 1'b1);
    @(negedge clock);  // Grant registers on the edge that sees both requests
    check_value("m0_grant one cycle after both request", 32'(m0_grant), 32'd1);
    check_value("m1_grant while master 0 owns the bus", 32'(m1_grant), 32'd0);
    write_byte(0, make_address(1, 12'h3f0), value);
    read_check(0, make_address(1, 12'h3f0), value);
    release_bus(0);
    wait_for_grant(1);
    check_value("m0_grant while master 1 owns the bus", 32'(m0_grant), 32'd0);
    read_check(1, make_address(1, 12'h3f0), value);  // Master 0's byte
    release_bus(1);
    check_value("m0_grant back in idle", 32'(m0_grant), 32'd0);
  endtask

  task automatic test_hold_limit();
    int    held = 0;
    data_t value;
    value = random_byte();
    set_request(0, 1'b1);
    wait_for_grant(0);
    set_request(1, 1'b1);
    while (m0_grant && held <= `ARB_HOLD_LIMIT + 1) begin
      @(negedge clock);
      held++;
    end
    check_value("master 0 gave up the bus within the hold limit",
                32'(held <= `ARB_HOLD_LIMIT + 1), 32'd1);
    check_value("m1_grant after the hold limit", 32'(m1_grant), 32'd1);
    write_byte(1, make_address(2, 12'habc), value);
    read_check(1, make_address(2, 12'habc), value);
    release_bus(1);
    wait_for_grant(0);  // Master 0 never dropped its request
    read_check(0, make_address(2, 12'habc), value);
    release_bus(0);
  endtask

  initial begin
    reset = 1'b1;
    m0_request = 1'b0;
    m0_write   = 1'b0;
    m0_address = '0;
    m0_valid   = 1'b0;
    m0_wdata   = '0;
    m1_request = 1'b0;
    m1_write   = 1'b0;
    m1_address = '0;
    m1_valid   = 1'b0;
    m1_wdata   = '0;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    test_reset_state();
    test_write_read_slaves();
    test_independence_alias();
    test_priority_from_idle();
    test_hold_limit();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
